// ==== dv/adxl_slave_model.sv ====
module adxl_slave_model (
	input  logic i_scl,
	input  logic i_sda,
	output logic o_sda_low
);

	typedef enum logic [1:0] {
		M_IDLE  = 2'd0,
		M_ADDR  = 2'd1,
		M_WDATA = 2'd2,
		M_RDATA = 2'd3
	} model_state_t;

	logic [7:0]   regs [256];
	logic [7:0]   ptr;
	logic [7:0]   rx_byte;
	logic [7:0]   tx_byte;
	logic         ptr_pending;
	logic         ignore_addr;
	model_state_t state;
	int           bitn;
	int           rd_count;
	int           nack_count;
	int           nack_byte;

	initial begin
		for (int i = 0; i < 256; i++) begin
			regs[i] = (i * 37 + 11) % 256;
		end
		ptr         = 8'h00;
		rx_byte     = 8'h00;
		tx_byte     = 8'h00;
		ptr_pending = 1'b0;
		ignore_addr = 1'b0;
		state       = M_IDLE;
		bitn        = 0;
		rd_count    = 0;
		nack_count  = 0;
		nack_byte   = 0;
		o_sda_low   = 1'b0;
	end

	// start, sda falls while scl is high
	always @(negedge i_sda) begin
		if (i_scl === 1'b1) begin
			state     = M_ADDR;
			bitn      = 0;
			o_sda_low = 1'b0;
		end
	end

	// stop, sda rises while scl is high
	always @(posedge i_sda) begin
		if (i_scl === 1'b1) begin
			state     = M_IDLE;
			o_sda_low = 1'b0;
		end
	end

	// bits are taken on the rising scl edge
	always @(posedge i_scl) begin
		if (state != M_IDLE) begin
			if (bitn < 8) begin
				rx_byte = {rx_byte[6:0], i_sda};
			end else if (state == M_RDATA && i_sda === 1'b1) begin
				// master ends the read with a nack
				nack_count = nack_count + 1;
				nack_byte  = rd_count;
				state      = M_IDLE;
			end
			bitn = bitn + 1;
		end
	end

	// sda only changes while scl is low
	always @(negedge i_scl) begin
		if (state == M_IDLE) begin
			o_sda_low = 1'b0;
		end else if (bitn == 8) begin
			case (state)
				M_ADDR: begin
					if (rx_byte[7:1] == adxl_pkg::DEV_ADDR && !ignore_addr) begin
						o_sda_low = 1'b1;
						if (rx_byte[0]) begin
							state    = M_RDATA;
							rd_count = 0;
						end else begin
							state       = M_WDATA;
							ptr_pending = 1'b1;
						end
					end else begin
						state = M_IDLE;
					end
				end
				M_WDATA: begin
					// first written byte sets the pointer
					if (ptr_pending) begin
						ptr         = rx_byte;
						ptr_pending = 1'b0;
					end else begin
						regs[ptr] = rx_byte;
						ptr       = ptr + 8'd1;
					end
					o_sda_low = 1'b1;
				end
				default: o_sda_low = 1'b0;
			endcase
		end else if (bitn == 9) begin
			bitn = 0;
			if (state == M_RDATA) begin
				tx_byte   = regs[ptr];
				ptr       = ptr + 8'd1;
				rd_count  = rd_count + 1;
				o_sda_low = ~tx_byte[7];
			end else begin
				o_sda_low = 1'b0;
			end
		end else if (state == M_RDATA && bitn > 0) begin
			o_sda_low = ~tx_byte[7 - bitn];
		end
	end

endmodule

// ==== dv/tb_adxl_i2c.sv ====
module tb_adxl_i2c;

	localparam int TIMEOUT_CLKS = 200000;

	logic                i_clk;
	logic                i_rst_n;
	logic                i_start;
	adxl_pkg::op_t       i_op;
	adxl_pkg::clk_rate_t i_clk_rate;
	logic [7:0]          i_reg_addr;
	logic [7:0]          i_w_data;
	logic                o_busy;
	logic                o_done;
	logic                o_nack;
	logic [7:0]          o_rd_data;
	adxl_pkg::sample_t   o_temp;
	adxl_pkg::sample_t   o_acc_x;
	adxl_pkg::sample_t   o_acc_y;
	adxl_pkg::sample_t   o_acc_z;
	logic                o_scl_low;
	logic                o_sda_low;
	logic                slave_sda_low;
	logic                scl_line;
	logic                sda_line;

	// wired and open drain lines with pullups
	assign scl_line = ~o_scl_low;
	assign sda_line = ~(o_sda_low | slave_sda_low);

	adxl_i2c_top adxl_i2c_top_inst (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (i_start),
		.i_op       (i_op),
		.i_clk_rate (i_clk_rate),
		.i_reg_addr (i_reg_addr),
		.i_w_data   (i_w_data),
		.i_sda      (sda_line),
		.o_busy     (o_busy),
		.o_done     (o_done),
		.o_nack     (o_nack),
		.o_rd_data  (o_rd_data),
		.o_temp     (o_temp),
		.o_acc_x    (o_acc_x),
		.o_acc_y    (o_acc_y),
		.o_acc_z    (o_acc_z),
		.o_scl_low  (o_scl_low),
		.o_sda_low  (o_sda_low)
	);

	adxl_slave_model adxl_slave_model_inst (
		.i_scl     (scl_line),
		.i_sda     (sda_line),
		.o_sda_low (slave_sda_low)
	);

	initial begin
		i_clk = 1'b0;
	end

	always #2 i_clk = ~i_clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch at %0t: %s is 0x%02h, expected 0x%02h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_sample(input string what, input adxl_pkg::sample_t got,
			input adxl_pkg::sample_t exp);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch at %0t: %s is %0d, expected %0d",
				$time, what, got, exp));
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch at %0t: %s is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	// quarter bit length in clocks for each rate
	function automatic int qtr_clocks(input adxl_pkg::clk_rate_t rate);
		case (rate)
			adxl_pkg::RATE_100K: return 250;
			adxl_pkg::RATE_400K: return 63;
			adxl_pkg::RATE_1M:   return 25;
			default:             return 8;
		endcase
	endfunction

	// 20 bit axis from three bytes with sign bit 19
	function automatic adxl_pkg::sample_t axis_value(input logic [7:0] hi,
			input logic [7:0] mid, input logic [7:0] lo);
		int raw;
		raw = hi * 4096 + mid * 16 + lo / 16;
		if (raw >= 524288) begin
			raw = raw - 1048576;
		end
		return raw;
	endfunction

	task automatic pulse_start(input adxl_pkg::op_t op, input logic [7:0] addr,
			input logic [7:0] data);
		@(posedge i_clk);
		#1;
		i_op       = op;
		i_reg_addr = addr;
		i_w_data   = data;
		i_start    = 1'b1;
		@(posedge i_clk);
		#1;
		i_start = 1'b0;
	endtask

	// returns at the falling clock edge where o_done is high
	task automatic wait_done();
		int n;
		n = 0;
		@(negedge i_clk);
		while (o_done !== 1'b1) begin
			if (n >= TIMEOUT_CLKS) begin
				fail_run("timeout: o_done never came");
			end
			n = n + 1;
			@(negedge i_clk);
		end
	endtask

	task automatic wait_scl(input logic level);
		int n;
		n = 0;
		@(negedge i_clk);
		while (scl_line !== level) begin
			if (n >= TIMEOUT_CLKS) begin
				fail_run("timeout: scl line did not reach the expected level");
			end
			n = n + 1;
			@(negedge i_clk);
		end
	endtask

	task automatic write_then_read_back();
		logic [7:0] addr;
		logic [7:0] data;
		addr = $urandom % 256;
		data = $urandom % 256;
		pulse_start(adxl_pkg::OP_WRITE_REG, addr, data);
		wait_done();
		check_bit("o_nack after write", o_nack, 1'b0);
		check_byte("device register", adxl_slave_model_inst.regs[addr], data);
		pulse_start(adxl_pkg::OP_READ_REG, addr, 8'h00);
		wait_done();
		check_bit("o_nack after read", o_nack, 1'b0);
		check_byte("o_rd_data", o_rd_data, data);
	endtask

	task automatic temperature_read();
		logic [7:0] b0;
		logic [7:0] b1;
		b0 = $urandom % 256;
		b1 = $urandom % 256;
		adxl_slave_model_inst.regs[8'h06] = b0;
		adxl_slave_model_inst.regs[8'h07] = b1;
		pulse_start(adxl_pkg::OP_READ_TEMP, 8'h00, 8'h00);
		wait_done();
		check_bit("o_nack after temperature", o_nack, 1'b0);
		check_sample("o_temp", o_temp, (b0 % 16) * 256 + b1);
	endtask

	task automatic acceleration_read();
		logic [7:0] b [9];
		int         nacks_before;
		for (int i = 0; i < 9; i++) begin
			b[i] = $urandom % 256;
		end
		// negative x and positive z axis
		b[0] = b[0] | 8'h80;
		b[6] = b[6] & 8'h7F;
		for (int i = 0; i < 9; i++) begin
			adxl_slave_model_inst.regs[8 + i] = b[i];
		end
		nacks_before = adxl_slave_model_inst.nack_count;
		pulse_start(adxl_pkg::OP_READ_ACCEL, 8'h00, 8'h00);
		wait_done();
		check_bit("o_nack after acceleration", o_nack, 1'b0);
		check_sample("o_acc_x", o_acc_x, axis_value(b[0], b[1], b[2]));
		check_sample("o_acc_y", o_acc_y, axis_value(b[3], b[4], b[5]));
		check_sample("o_acc_z", o_acc_z, axis_value(b[6], b[7], b[8]));
		check_sample("nacks seen by device",
			adxl_slave_model_inst.nack_count - nacks_before, 1);
		check_sample("byte that got the nack", adxl_slave_model_inst.nack_byte, 9);
	endtask

	task automatic wrong_address_abort();
		logic [7:0]        rd_prev;
		adxl_pkg::sample_t temp_prev;
		adxl_pkg::sample_t x_prev;
		adxl_pkg::sample_t y_prev;
		adxl_pkg::sample_t z_prev;
		rd_prev   = o_rd_data;
		temp_prev = o_temp;
		x_prev    = o_acc_x;
		y_prev    = o_acc_y;
		z_prev    = o_acc_z;
		adxl_slave_model_inst.ignore_addr = 1'b1;
		// the byte buffer still holds the acceleration bytes
		pulse_start(adxl_pkg::OP_READ_TEMP, 8'h00, 8'h00);
		wait_done();
		check_bit("o_nack on wrong address", o_nack, 1'b1);
		check_byte("o_rd_data held", o_rd_data, rd_prev);
		check_sample("o_temp held", o_temp, temp_prev);
		check_sample("o_acc_x held", o_acc_x, x_prev);
		check_sample("o_acc_y held", o_acc_y, y_prev);
		check_sample("o_acc_z held", o_acc_z, z_prev);
		adxl_slave_model_inst.ignore_addr = 1'b0;
	endtask

	task automatic rate_and_busy();
		adxl_pkg::clk_rate_t rates [2];
		logic [7:0]          addr;
		logic [7:0]          data;
		int                  high;
		rates[0] = adxl_pkg::RATE_400K;
		rates[1] = adxl_pkg::RATE_3M4;
		for (int r = 0; r < 2; r++) begin
			addr = $urandom % 256;
			data = $urandom % 256;
			@(posedge i_clk);
			#1;
			i_clk_rate = rates[r];
			pulse_start(adxl_pkg::OP_WRITE_REG, addr, data);
			// skip the start and the first bit, then time the second bit
			wait_scl(1'b0);
			wait_scl(1'b1);
			wait_scl(1'b0);
			wait_scl(1'b1);
			high = 0;
			while (scl_line === 1'b1) begin
				if (high >= TIMEOUT_CLKS) begin
					fail_run("timeout: scl line stuck high");
				end
				high = high + 1;
				@(negedge i_clk);
			end
			check_sample("scl high clocks", high, 2 * qtr_clocks(rates[r]));
			check_bit("o_busy during write", o_busy, 1'b1);
			pulse_start(adxl_pkg::OP_READ_REG, addr, 8'h00);
			wait_done();
			check_byte("device register", adxl_slave_model_inst.regs[addr], data);
			// a start taken while busy would end in a second o_done
			repeat (250 * qtr_clocks(rates[r])) begin
				@(negedge i_clk);
				check_bit("o_done after ignored start", o_done, 1'b0);
			end
		end
	endtask

	initial begin
		void'($urandom(10));
		i_rst_n    = 1'b0;
		i_start    = 1'b0;
		i_op       = adxl_pkg::OP_WRITE_REG;
		i_clk_rate = adxl_pkg::RATE_3M4;
		i_reg_addr = 8'h00;
		i_w_data   = 8'h00;
		repeat (8) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;
		check_bit("o_busy after reset", o_busy, 1'b0);
		check_bit("o_done after reset", o_done, 1'b0);
		check_bit("o_nack after reset", o_nack, 1'b0);
		check_bit("o_scl_low after reset", o_scl_low, 1'b0);
		check_bit("o_sda_low after reset", o_sda_low, 1'b0);
		check_byte("o_rd_data after reset", o_rd_data, 8'h00);
		check_sample("o_temp after reset", o_temp, 0);
		check_sample("o_acc_x after reset", o_acc_x, 0);
		check_sample("o_acc_y after reset", o_acc_y, 0);
		check_sample("o_acc_z after reset", o_acc_z, 0);
		write_then_read_back();
		temperature_read();
		acceleration_read();
		wrong_address_abort();
		rate_and_busy();
		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== src/adxl_i2c_top.sv ====
module adxl_i2c_top (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  logic                i_start,
	input  adxl_pkg::op_t       i_op,
	input  adxl_pkg::clk_rate_t i_clk_rate,
	input  logic [7:0]          i_reg_addr,
	input  logic [7:0]          i_w_data,
	input  logic                i_sda,
	output logic                o_busy,
	output logic                o_done,
	output logic                o_nack,
	output logic [7:0]          o_rd_data,
	output adxl_pkg::sample_t   o_temp,
	output adxl_pkg::sample_t   o_acc_x,
	output adxl_pkg::sample_t   o_acc_y,
	output adxl_pkg::sample_t   o_acc_z,
	output logic                o_scl_low,
	output logic                o_sda_low
);

	logic          tick;
	logic          commit;
	adxl_pkg::op_t op_latched;

	i2c_byte_if byte_bus ();

	scl_tick_gen scl_tick_gen_inst (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_rate  (i_clk_rate),
		.o_tick  (tick)
	);

	adxl_txn_sequencer adxl_txn_sequencer_inst (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (i_start),
		.i_op       (i_op),
		.i_reg_addr (i_reg_addr),
		.i_w_data   (i_w_data),
		.o_busy     (o_busy),
		.o_nack     (o_nack),
		.o_commit   (commit),
		.o_done     (o_done),
		.o_op       (op_latched),
		.bus        (byte_bus.seq)
	);

	i2c_bit_engine i2c_bit_engine_inst (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_tick    (tick),
		.i_sda     (i_sda),
		.o_scl_low (o_scl_low),
		.o_sda_low (o_sda_low),
		.bus       (byte_bus.engine)
	);

	sample_assembler sample_assembler_inst (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_op      (op_latched),
		.i_commit  (commit),
		.o_rd_data (o_rd_data),
		.o_temp    (o_temp),
		.o_acc_x   (o_acc_x),
		.o_acc_y   (o_acc_y),
		.o_acc_z   (o_acc_z),
		.bus       (byte_bus.mon)
	);

endmodule

// ==== src/adxl_pkg.sv ====
package adxl_pkg;

	// operations selected at the top level
	typedef enum logic [1:0] {
		OP_WRITE_REG  = 2'd0,
		OP_READ_REG   = 2'd1,
		OP_READ_TEMP  = 2'd2,
		OP_READ_ACCEL = 2'd3
	} op_t;

	// byte level commands for the bit engine
	typedef enum logic [1:0] {
		CMD_START = 2'd0,
		CMD_WRITE = 2'd1,
		CMD_READ  = 2'd2,
		CMD_STOP  = 2'd3
	} byte_cmd_t;

	typedef enum logic [1:0] {
		RATE_100K = 2'd0,
		RATE_400K = 2'd1,
		RATE_1M   = 2'd2,
		RATE_3M4  = 2'd3
	} clk_rate_t;

	localparam int TICK_CNT_W = 8;

	// quarter bit length in 100 MHz clocks, indexed by clk_rate_t
	localparam logic [TICK_CNT_W-1:0] QTR_DIV [4] = '{8'd250, 8'd63, 8'd25, 8'd8};

	localparam logic [6:0] DEV_ADDR   = 7'h1D;
	localparam logic [7:0] REG_TEMP2  = 8'h06;
	localparam logic [7:0] REG_XDATA3 = 8'h08;

	localparam int TEMP_BYTES  = 2;
	localparam int ACCEL_BYTES = 9;

	typedef logic signed [31:0] sample_t;

endpackage

// ==== src/adxl_txn_sequencer.sv ====
module adxl_txn_sequencer (
	input  logic          i_clk,
	input  logic          i_rst_n,
	input  logic          i_start,
	input  adxl_pkg::op_t i_op,
	input  logic [7:0]    i_reg_addr,
	input  logic [7:0]    i_w_data,
	output logic          o_busy,
	output logic          o_nack,
	output logic          o_commit,
	output logic          o_done,
	output adxl_pkg::op_t o_op,
	i2c_byte_if.seq       bus
);

	typedef enum logic [1:0] {
		S_IDLE  = 2'd0,
		S_ISSUE = 2'd1,
		S_WAIT  = 2'd2,
		S_END   = 2'd3
	} seq_state_t;

	seq_state_t          state;
	logic [3:0]          step;
	logic                nack_seen;
	logic [7:0]          reg_q;
	logic [7:0]          data_q;
	logic [3:0]          n_bytes;
	logic [3:0]          final_step;
	logic [7:0]          reg_byte;
	adxl_pkg::byte_cmd_t cmd_c;
	logic [7:0]          byte_c;
	logic                is_addr;
	logic                is_final;

	// read length and register pointer of the latched operation
	always_comb begin
		case (o_op)
			adxl_pkg::OP_READ_TEMP: begin
				n_bytes  = 4'(adxl_pkg::TEMP_BYTES);
				reg_byte = adxl_pkg::REG_TEMP2;
			end
			adxl_pkg::OP_READ_ACCEL: begin
				n_bytes  = 4'(adxl_pkg::ACCEL_BYTES);
				reg_byte = adxl_pkg::REG_XDATA3;
			end
			default: begin
				n_bytes  = 4'd1;
				reg_byte = reg_q;
			end
		endcase
		final_step = (o_op == adxl_pkg::OP_WRITE_REG) ? 4'd4 : 4'd6 + n_bytes;
	end

	// byte plan: pointer write transaction, then the read transaction
	always_comb begin
		cmd_c   = adxl_pkg::CMD_READ;
		byte_c  = 8'h00;
		is_addr = 1'b0;
		if (step == final_step) begin
			cmd_c = adxl_pkg::CMD_STOP;
		end else begin
			case (step)
				4'd0: cmd_c = adxl_pkg::CMD_START;
				4'd1: begin
					cmd_c   = adxl_pkg::CMD_WRITE;
					byte_c  = {adxl_pkg::DEV_ADDR, 1'b0};
					is_addr = 1'b1;
				end
				4'd2: begin
					cmd_c  = adxl_pkg::CMD_WRITE;
					byte_c = reg_byte;
				end
				4'd3: begin
					// data byte for writes, end of pointer phase for reads
					cmd_c  = (o_op == adxl_pkg::OP_WRITE_REG) ? adxl_pkg::CMD_WRITE
					                                          : adxl_pkg::CMD_STOP;
					byte_c = data_q;
				end
				4'd4: cmd_c = adxl_pkg::CMD_START;
				4'd5: begin
					cmd_c   = adxl_pkg::CMD_WRITE;
					byte_c  = {adxl_pkg::DEV_ADDR, 1'b1};
					is_addr = 1'b1;
				end
				default: cmd_c = adxl_pkg::CMD_READ;
			endcase
		end
	end

	assign is_final      = (step == final_step);
	assign bus.cmd       = cmd_c;
	assign bus.wr_byte   = byte_c;
	// nack on the last read byte only
	assign bus.ack_out   = (step == 4'd5 + n_bytes);
	assign bus.cmd_valid = (state == S_ISSUE);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= S_IDLE;
			step      <= 4'd0;
			o_op      <= adxl_pkg::OP_WRITE_REG;
			o_busy    <= 1'b0;
			o_nack    <= 1'b0;
			nack_seen <= 1'b0;
			o_commit  <= 1'b0;
			o_done    <= 1'b0;
		end else begin
			o_commit <= 1'b0;
			o_done   <= 1'b0;
			case (state)
				S_IDLE: begin
					if (i_start) begin
						o_op      <= i_op;
						step      <= 4'd0;
						nack_seen <= 1'b0;
						o_busy    <= 1'b1;
						state     <= S_ISSUE;
					end
				end
				S_ISSUE: state <= S_WAIT;
				S_WAIT: begin
					if (bus.done) begin
						if (is_final) begin
							o_commit <= ~nack_seen;
							state    <= S_END;
						end else if (is_addr && bus.ack_in) begin
							// address not acknowledged, go straight to stop
							nack_seen <= 1'b1;
							step      <= final_step;
							state     <= S_ISSUE;
						end else begin
							step  <= step + 4'd1;
							state <= S_ISSUE;
						end
					end
				end
				default: begin
					o_done <= 1'b1;
					o_busy <= 1'b0;
					o_nack <= nack_seen;
					state  <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == S_IDLE && i_start) begin
			reg_q  <= i_reg_addr;
			data_q <= i_w_data;
		end
	end

endmodule

// ==== src/i2c_bit_engine.sv ====
module i2c_bit_engine (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_tick,
	input  logic       i_sda,
	output logic       o_scl_low,
	output logic       o_sda_low,
	i2c_byte_if.engine bus
);

	logic                active;
	adxl_pkg::byte_cmd_t cur_cmd;
	logic [1:0]          qtr;
	logic [3:0]          bit_cnt;
	logic                done_q;
	logic [7:0]          shift_q;
	logic                ack_out_q;
	logic                ack_in_q;
	logic                ack_bit;
	logic                bit_sda_low;
	logic                accept;
	logic                step;

	assign accept  = ~active & bus.cmd_valid;
	assign step    = active & i_tick;
	// ninth bit of a byte carries the acknowledge
	assign ack_bit = (bit_cnt == 4'd8);

	always_comb begin
		if (cur_cmd == adxl_pkg::CMD_WRITE) begin
			bit_sda_low = ack_bit ? 1'b0 : ~shift_q[7];
		end else begin
			bit_sda_low = ack_bit ? ~ack_out_q : 1'b0;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			active    <= 1'b0;
			cur_cmd   <= adxl_pkg::CMD_STOP;
			qtr       <= 2'd0;
			bit_cnt   <= 4'd0;
			done_q    <= 1'b0;
			o_scl_low <= 1'b0;
			o_sda_low <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (accept) begin
				active  <= 1'b1;
				cur_cmd <= bus.cmd;
				qtr     <= 2'd0;
				bit_cnt <= 4'd0;
			end else if (step) begin
				qtr <= qtr + 2'd1;
				case (cur_cmd)
					adxl_pkg::CMD_START: begin
						// sda falls with scl high, then scl goes low
						if (qtr == 2'd0) begin
							o_sda_low <= 1'b1;
						end else begin
							o_scl_low <= 1'b1;
							active    <= 1'b0;
							done_q    <= 1'b1;
						end
					end
					adxl_pkg::CMD_STOP: begin
						case (qtr)
							2'd0: o_sda_low <= 1'b1;
							2'd1: o_scl_low <= 1'b0;
							default: begin
								// sda rises with scl high, bus left idle
								o_sda_low <= 1'b0;
								active    <= 1'b0;
								done_q    <= 1'b1;
							end
						endcase
					end
					default: begin
						// data and ack bits, scl high in quarters 1 and 2
						case (qtr)
							2'd0: o_sda_low <= bit_sda_low;
							2'd1: o_scl_low <= 1'b0;
							2'd3: begin
								o_scl_low <= 1'b1;
								bit_cnt   <= bit_cnt + 4'd1;
								if (ack_bit) begin
									active <= 1'b0;
									done_q <= 1'b1;
								end
							end
						endcase
					end
				endcase
			end
		end
	end

	// shift register and acknowledge capture
	always_ff @(posedge i_clk) begin
		if (accept) begin
			shift_q   <= bus.wr_byte;
			ack_out_q <= bus.ack_out;
		end else if (step) begin
			if (!ack_bit && cur_cmd == adxl_pkg::CMD_WRITE && qtr == 2'd3) begin
				shift_q <= {shift_q[6:0], 1'b0};
			end
			if (!ack_bit && cur_cmd == adxl_pkg::CMD_READ && qtr == 2'd2) begin
				shift_q <= {shift_q[6:0], i_sda};
			end
			if (ack_bit && cur_cmd == adxl_pkg::CMD_WRITE && qtr == 2'd2) begin
				ack_in_q <= i_sda;
			end
		end
	end

	assign bus.done    = done_q;
	assign bus.rd_byte = shift_q;
	assign bus.ack_in  = ack_in_q;

endmodule

// ==== src/i2c_byte_if.sv ====
interface i2c_byte_if;

	adxl_pkg::byte_cmd_t cmd;
	logic                cmd_valid;
	logic [7:0]          wr_byte;
	// 0 acknowledges a read byte
	logic                ack_out;
	logic                done;
	logic [7:0]          rd_byte;
	// device acknowledge after a write, 1 means nack
	logic                ack_in;

	modport seq (
		output cmd, cmd_valid, wr_byte, ack_out,
		input  done, rd_byte, ack_in
	);

	modport engine (
		input  cmd, cmd_valid, wr_byte, ack_out,
		output done, rd_byte, ack_in
	);

	modport mon (
		input cmd, cmd_valid, wr_byte, ack_out, done, rd_byte, ack_in
	);

endinterface

// ==== src/sample_assembler.sv ====
module sample_assembler (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  adxl_pkg::op_t     i_op,
	input  logic              i_commit,
	output logic [7:0]        o_rd_data,
	output adxl_pkg::sample_t o_temp,
	output adxl_pkg::sample_t o_acc_x,
	output adxl_pkg::sample_t o_acc_y,
	output adxl_pkg::sample_t o_acc_z,
	i2c_byte_if.mon           bus
);

	logic [7:0] rx_buf [adxl_pkg::ACCEL_BYTES];
	logic [3:0] idx;
	logic       capture;

	// 20 bit axis, low nibble of the third byte is unused
	function automatic adxl_pkg::sample_t axis(
		input logic [7:0] b_hi,
		input logic [7:0] b_mid,
		input logic [7:0] b_lo
	);
		axis = {{12{b_hi[7]}}, b_hi, b_mid, b_lo[7:4]};
	endfunction

	assign capture = bus.done && (bus.cmd == adxl_pkg::CMD_READ)
	                 && (idx < 4'(adxl_pkg::ACCEL_BYTES));

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			idx <= 4'd0;
		end else if (bus.cmd_valid && bus.cmd == adxl_pkg::CMD_START) begin
			idx <= 4'd0;
		end else if (capture) begin
			idx <= idx + 4'd1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (capture) begin
			rx_buf[idx] <= bus.rd_byte;
		end
	end

	// only the results of the finished operation change
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_rd_data <= 8'h00;
			o_temp    <= '0;
			o_acc_x   <= '0;
			o_acc_y   <= '0;
			o_acc_z   <= '0;
		end else if (i_commit) begin
			case (i_op)
				adxl_pkg::OP_READ_REG: o_rd_data <= rx_buf[0];
				adxl_pkg::OP_READ_TEMP: o_temp <= {20'd0, rx_buf[0][3:0], rx_buf[1]};
				adxl_pkg::OP_READ_ACCEL: begin
					o_acc_x <= axis(rx_buf[0], rx_buf[1], rx_buf[2]);
					o_acc_y <= axis(rx_buf[3], rx_buf[4], rx_buf[5]);
					o_acc_z <= axis(rx_buf[6], rx_buf[7], rx_buf[8]);
				end
				default: o_rd_data <= o_rd_data;
			endcase
		end
	end

endmodule

// ==== src/scl_tick_gen.sv ====
module scl_tick_gen (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  adxl_pkg::clk_rate_t i_rate,
	output logic                o_tick
);

	logic [adxl_pkg::TICK_CNT_W-1:0] cnt;

	// free running down counter, new rate picked up on reload
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else if (cnt == '0) begin
			cnt    <= adxl_pkg::QTR_DIV[i_rate] - 1'b1;
			o_tick <= 1'b1;
		end else begin
			cnt    <= cnt - 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule

// ==== verilog.f ====
src/adxl_pkg.sv
src/i2c_byte_if.sv
src/scl_tick_gen.sv
src/adxl_txn_sequencer.sv
src/i2c_bit_engine.sv
src/sample_assembler.sv
src/adxl_i2c_top.sv
dv/adxl_slave_model.sv
dv/tb_adxl_i2c.sv
